// File: rvPkg.sv
package rvPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0] regAddrT;
	typedef logic [5:0] imemAddrT;

	localparam int imemWords = 64;
	localparam int dmemWords = 64;

	// Major opcodes, instr[6:0]
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opAuipc = 7'b0010111;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opReg = 7'b0110011;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd,
		aluPassB
	} aluOpT;

	typedef enum logic [2:0] {
		brNone,
		brEq,
		brNe,
		brLt,
		brGe,
		brLtu,
		brGeu
	} branchTypeT;

	typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immTypeT;

	typedef enum logic [1:0] {wbAlu, wbMem, wbPcPlus4} wbSelT;

	typedef enum logic [1:0] {memByte, memHalf, memWord} memSizeT;

endpackage

// File: rvDecoder.sv
`timescale 1ns/10ps

module rvDecoder (
	input  rvPkg::wordT instr,
	output rvPkg::aluOpT aluOp,
	output logic aluSrcImm,
	output logic aluSrcPc,
	output logic regWrite,
	output logic memWrite,
	output logic memRead,
	output logic memUnsigned,
	output logic isJal,
	output logic isJalr,
	output logic illegal,
	output rvPkg::memSizeT memSize,
	output rvPkg::immTypeT immType,
	output rvPkg::wbSelT wbSel,
	output rvPkg::branchTypeT branchType
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic f7Zero;
	logic f7Alt;
	logic isReg;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign f7Zero = (funct7 == 7'b0000000);
	assign f7Alt = (funct7 == 7'b0100000);
	assign isReg = (opcode == rvPkg::opReg);

	always_comb begin
		aluOp = rvPkg::aluAdd;
		aluSrcImm = 1'b0;
		aluSrcPc = 1'b0;
		regWrite = 1'b0;
		memWrite = 1'b0;
		memRead = 1'b0;
		memUnsigned = 1'b0;
		isJal = 1'b0;
		isJalr = 1'b0;
		illegal = 1'b0;
		memSize = rvPkg::memWord;
		immType = rvPkg::immI;
		wbSel = rvPkg::wbAlu;
		branchType = rvPkg::brNone;
		case (opcode)
			rvPkg::opLui: begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				immType = rvPkg::immU;
				aluOp = rvPkg::aluPassB;
			end
			rvPkg::opAuipc: begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				aluSrcPc = 1'b1;
				immType = rvPkg::immU;
			end
			rvPkg::opJal: begin
				regWrite = 1'b1;
				isJal = 1'b1;
				immType = rvPkg::immJ;
				wbSel = rvPkg::wbPcPlus4;
			end
			rvPkg::opJalr: begin
				// ALU forms rs1 + imm as the target
				regWrite = 1'b1;
				isJalr = 1'b1;
				aluSrcImm = 1'b1;
				wbSel = rvPkg::wbPcPlus4;
				illegal = (funct3 != 3'b000);
			end
			rvPkg::opBranch: begin
				immType = rvPkg::immB;
				case (funct3)
					3'b000: branchType = rvPkg::brEq;
					3'b001: branchType = rvPkg::brNe;
					3'b100: branchType = rvPkg::brLt;
					3'b101: branchType = rvPkg::brGe;
					3'b110: branchType = rvPkg::brLtu;
					3'b111: branchType = rvPkg::brGeu;
					default: illegal = 1'b1;
				endcase
			end
			rvPkg::opLoad: begin
				regWrite = 1'b1;
				memRead = 1'b1;
				aluSrcImm = 1'b1;
				wbSel = rvPkg::wbMem;
				memUnsigned = funct3[2];
				case (funct3)
					3'b000, 3'b100: memSize = rvPkg::memByte;
					3'b001, 3'b101: memSize = rvPkg::memHalf;
					3'b010: memSize = rvPkg::memWord;
					default: illegal = 1'b1;
				endcase
			end
			rvPkg::opStore: begin
				memWrite = 1'b1;
				aluSrcImm = 1'b1;
				immType = rvPkg::immS;
				case (funct3)
					3'b000: memSize = rvPkg::memByte;
					3'b001: memSize = rvPkg::memHalf;
					3'b010: memSize = rvPkg::memWord;
					default: illegal = 1'b1;
				endcase
			end
			rvPkg::opImm, rvPkg::opReg: begin
				regWrite = 1'b1;
				aluSrcImm = !isReg;
				// funct7 must be zero for R-type unless noted per item
				illegal = isReg && !f7Zero;
				case (funct3)
					3'b000: begin
						aluOp = (isReg && f7Alt) ? rvPkg::aluSub : rvPkg::aluAdd;
						illegal = isReg && !(f7Zero || f7Alt);
					end
					3'b001: begin
						aluOp = rvPkg::aluSll;
						illegal = !f7Zero;
					end
					3'b010: aluOp = rvPkg::aluSlt;
					3'b011: aluOp = rvPkg::aluSltu;
					3'b100: aluOp = rvPkg::aluXor;
					3'b101: begin
						aluOp = f7Alt ? rvPkg::aluSra : rvPkg::aluSrl;
						illegal = !(f7Zero || f7Alt);
					end
					3'b110: aluOp = rvPkg::aluOr;
					default: aluOp = rvPkg::aluAnd;
				endcase
			end
			default: illegal = 1'b1;
		endcase
		// Nothing may write or redirect on a bad encoding
		if (illegal) begin
			regWrite = 1'b0;
			memWrite = 1'b0;
			memRead = 1'b0;
			isJal = 1'b0;
			isJalr = 1'b0;
			branchType = rvPkg::brNone;
		end
	end

endmodule

// File: rvImmGen.sv
`timescale 1ns/10ps

module rvImmGen (
	input  rvPkg::wordT instr,
	input  rvPkg::immTypeT immType,
	output rvPkg::wordT imm
);

	always_comb begin
		case (immType)
			rvPkg::immS: begin
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			rvPkg::immB: begin
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			end
			rvPkg::immU: begin
				imm = {instr[31:12], 12'b0};
			end
			rvPkg::immJ: begin
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			end
			default: begin
				imm = {{20{instr[31]}}, instr[31:20]};
			end
		endcase
	end

endmodule

// File: rvRegFile.sv
`timescale 1ns/10ps

module rvRegFile (
	input  logic rstn,
	input  logic rstN,
	input  rvPkg::regAddrT rs1,
	input  rvPkg::regAddrT rs2,
	input  rvPkg::regAddrT rd,
	input  logic we,
	input  rvPkg::wordT wd,
	output rvPkg::wordT rd1,
	output rvPkg::wordT rd2
);

	rvPkg::wordT regs [32];

	always_ff @(posedge rstn or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != '0) begin
			regs[rd] <= wd;
		end
	end

	// Index zero reads the stored x0, held at zero
	assign rd1 = regs[rs1];
	assign rd2 = regs[rs2];

	// x0 storage must survive every retired write
	x0StaysZero: assert property (@(posedge rstn) disable iff (!rstN) regs[0] == '0)
		else $error("x0 storage became nonzero");

endmodule

// File: rvAlu.sv
`timescale 1ns/10ps

module rvAlu (
	input  rvPkg::wordT opA,
	input  rvPkg::wordT opB,
	input  rvPkg::aluOpT aluOp,
	input  rvPkg::branchTypeT branchType,
	output rvPkg::wordT result,
	output logic taken
);

	logic [4:0] shamt;
	logic isEq;
	logic ltSigned;
	logic ltUnsigned;

	assign shamt = opB[4:0];
	assign isEq = (opA == opB);
	assign ltSigned = ($signed(opA) < $signed(opB));
	assign ltUnsigned = (opA < opB);

	always_comb begin
		case (aluOp)
			rvPkg::aluSub: result = opA - opB;
			rvPkg::aluSll: result = opA << shamt;
			rvPkg::aluSlt: result = {31'b0, ltSigned};
			rvPkg::aluSltu: result = {31'b0, ltUnsigned};
			rvPkg::aluXor: result = opA ^ opB;
			rvPkg::aluSrl: result = opA >> shamt;
			rvPkg::aluSra: result = $signed(opA) >>> shamt;
			rvPkg::aluOr: result = opA | opB;
			rvPkg::aluAnd: result = opA & opB;
			rvPkg::aluPassB: result = opB;
			default: result = opA + opB;
		endcase
	end

	// Branch compare runs beside the result path
	always_comb begin
		case (branchType)
			rvPkg::brEq: taken = isEq;
			rvPkg::brNe: taken = !isEq;
			rvPkg::brLt: taken = ltSigned;
			rvPkg::brGe: taken = !ltSigned;
			rvPkg::brLtu: taken = ltUnsigned;
			rvPkg::brGeu: taken = !ltUnsigned;
			default: taken = 1'b0;
		endcase
	end

endmodule

// File: rvFetch.sv
`timescale 1ns/10ps

module rvFetch (
	input  logic rstn,
	input  logic rstN,
	input  logic advance,
	input  logic imemWe,
	input  logic isJal,
	input  logic isJalr,
	input  logic taken,
	input  rvPkg::imemAddrT imemAddr,
	input  rvPkg::wordT imemData,
	input  rvPkg::wordT imm,
	input  rvPkg::wordT jalrTarget,
	output rvPkg::wordT pc,
	output rvPkg::wordT instr
);

	rvPkg::wordT imem [rvPkg::imemWords];
	rvPkg::imemAddrT pcIndex;
	rvPkg::wordT nextPc;

	always_ff @(posedge rstn) begin
		if (imemWe) begin
			imem[imemAddr] <= imemData;
		end
	end

	assign pcIndex = pc[2 +: $bits(rvPkg::imemAddrT)];
	assign instr = imem[pcIndex];

	always_comb begin
		if (isJalr) begin
			nextPc = {jalrTarget[31:1], 1'b0};
		end else if (isJal || taken) begin
			nextPc = pc + imm;
		end else begin
			nextPc = pc + 32'd4;
		end
	end

	always_ff @(posedge rstn or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else if (advance) begin
			pc <= nextPc;
		end
	end

	// Jump and branch targets come from decoder, ALU and immediate
	pcInRange: assert property (@(posedge rstn) disable iff (!rstN)
		pc[1:0] == 2'b00 && pc < rvPkg::imemWords * 4)
		else $error("pc %h misaligned or outside instruction memory", pc);

endmodule

// File: rvLoadStore.sv
`timescale 1ns/10ps

module rvLoadStore (
	input  logic rstn,
	input  logic rstN,
	input  logic memWrite,
	input  logic memRead,
	input  logic memUnsigned,
	input  rvPkg::memSizeT memSize,
	input  rvPkg::wordT addr,
	input  rvPkg::wordT storeData,
	output rvPkg::wordT loadData
);

	rvPkg::wordT dmem [rvPkg::dmemWords];
	logic [$clog2(rvPkg::dmemWords)-1:0] wordIdx;
	logic [1:0] offset;
	logic [3:0] byteEn;
	logic aligned;
	rvPkg::wordT laneData;
	rvPkg::wordT shifted;

	assign wordIdx = addr[2 +: $clog2(rvPkg::dmemWords)];
	assign offset = addr[1:0];

	// Replicate store data so every lane sees its bytes
	always_comb begin
		case (memSize)
			rvPkg::memByte: begin
				byteEn = 4'b0001 << offset;
				laneData = {4{storeData[7:0]}};
			end
			rvPkg::memHalf: begin
				byteEn = 4'b0011 << offset;
				laneData = {2{storeData[15:0]}};
			end
			default: begin
				byteEn = 4'b1111;
				laneData = storeData;
			end
		endcase
	end

	always_ff @(posedge rstn) begin
		if (memWrite) begin
			for (int b = 0; b < 4; b++) begin
				if (byteEn[b]) begin
					dmem[wordIdx][8*b +: 8] <= laneData[8*b +: 8];
				end
			end
		end
	end

	assign shifted = dmem[wordIdx] >> {offset, 3'b000};

	always_comb begin
		case (memSize)
			rvPkg::memByte: begin
				loadData = {{24{shifted[7] & !memUnsigned}}, shifted[7:0]};
			end
			rvPkg::memHalf: begin
				loadData = {{16{shifted[15] & !memUnsigned}}, shifted[15:0]};
			end
			default: loadData = shifted;
		endcase
	end

	assign aligned = (memSize == rvPkg::memWord) ? (offset == 2'b00) :
		(memSize == rvPkg::memHalf) ? !offset[0] : 1'b1;

	accessAligned: assert property (@(posedge rstn) disable iff (!rstN)
		(memRead || memWrite) |-> aligned)
		else $error("misaligned data access at %h", addr);

endmodule

// File: rvCore.sv
`timescale 1ns/10ps

module rvCore (
	input  logic rstn,
	input  logic rstN,
	input  logic run,
	input  logic imemWe,
	input  rvPkg::imemAddrT imemAddr,
	input  rvPkg::wordT imemData,
	output logic halted,
	output logic retireValid,
	output logic retireRegWrite,
	output rvPkg::wordT retirePc,
	output rvPkg::wordT retireRdData,
	output rvPkg::regAddrT retireRd
);

	rvPkg::wordT pc, instr, imm, rs1Data, rs2Data;
	rvPkg::wordT opA, opB, aluResult, loadData, wbData;
	rvPkg::regAddrT rdAddr;
	rvPkg::aluOpT aluOp;
	rvPkg::memSizeT memSize;
	rvPkg::immTypeT immType;
	rvPkg::wbSelT wbSel;
	rvPkg::branchTypeT branchType;
	logic aluSrcImm, aluSrcPc, regWrite, memWrite, memRead, memUnsigned;
	logic isJal, isJalr, illegal, taken, advance;

	// Execute only while running, never past a halt
	assign advance = run && !halted && !illegal;
	assign rdAddr = instr[11:7];

	always_ff @(posedge rstn or negedge rstN) begin
		if (!rstN) begin
			halted <= 1'b0;
		end else if (run && illegal) begin
			halted <= 1'b1;
		end
	end

	rvFetch fetch (
		.rstn(rstn), .rstN(rstN), .advance(advance),
		.imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
		.isJal(isJal), .isJalr(isJalr), .taken(taken),
		.imm(imm), .jalrTarget(aluResult), .pc(pc), .instr(instr)
	);

	rvDecoder decoder (
		.instr(instr), .aluOp(aluOp), .aluSrcImm(aluSrcImm), .aluSrcPc(aluSrcPc),
		.regWrite(regWrite), .memWrite(memWrite), .memRead(memRead),
		.memUnsigned(memUnsigned), .isJal(isJal), .isJalr(isJalr), .illegal(illegal),
		.memSize(memSize), .immType(immType), .wbSel(wbSel), .branchType(branchType)
	);

	rvImmGen immGen (.instr(instr), .immType(immType), .imm(imm));

	rvRegFile regFile (
		.rstn(rstn), .rstN(rstN),
		.rs1(instr[19:15]), .rs2(instr[24:20]), .rd(rdAddr),
		.we(regWrite && advance), .wd(wbData), .rd1(rs1Data), .rd2(rs2Data)
	);

	assign opA = aluSrcPc ? pc : rs1Data;
	assign opB = aluSrcImm ? imm : rs2Data;

	rvAlu alu (
		.opA(opA), .opB(opB), .aluOp(aluOp), .branchType(branchType),
		.result(aluResult), .taken(taken)
	);

	rvLoadStore loadStore (
		.rstn(rstn), .rstN(rstN),
		.memWrite(memWrite && advance), .memRead(memRead && advance),
		.memUnsigned(memUnsigned), .memSize(memSize),
		.addr(aluResult), .storeData(rs2Data), .loadData(loadData)
	);

	always_comb begin
		case (wbSel)
			rvPkg::wbMem: wbData = loadData;
			rvPkg::wbPcPlus4: wbData = pc + 32'd4;
			default: wbData = aluResult;
		endcase
	end

	always_ff @(posedge rstn or negedge rstN) begin
		if (!rstN) begin
			retireValid <= 1'b0;
			retireRegWrite <= 1'b0;
		end else begin
			retireValid <= advance;
			retireRegWrite <= advance && regWrite;
		end
	end

	// Payload of the retiring instruction
	always_ff @(posedge rstn) begin
		if (advance) begin
			retirePc <= pc;
			retireRd <= rdAddr;
			retireRdData <= wbData;
		end
	end

endmodule

// File: rvCoreTb.sv
`timescale 1ns/10ps

module rvCoreTb;

	localparam int retireTimeout = 16;
	localparam int haltTimeout = 16;
	localparam int quietCycles = 20;
	localparam logic [11:0] immVal = 12'h9a5;
	localparam logic [4:0] shiftI = 5'd13;

	logic rstn;
	logic rstN;
	logic run;
	logic imemWe;
	rvPkg::imemAddrT imemAddr;
	rvPkg::wordT imemData;
	logic halted;
	logic retireValid;
	logic retireRegWrite;
	rvPkg::wordT retirePc;
	rvPkg::wordT retireRdData;
	rvPkg::regAddrT retireRd;

	// Program image and the retire sequence it should produce
	rvPkg::wordT image [rvPkg::imemWords];
	rvPkg::wordT expPc [rvPkg::imemWords];
	logic expWr [rvPkg::imemWords];
	rvPkg::regAddrT expRd [rvPkg::imemWords];
	rvPkg::wordT expData [rvPkg::imemWords];
	int expCount;
	rvPkg::wordT buildPc;
	logic [7:0] dmemModel [rvPkg::dmemWords * 4];

	// Branch kinds with operands that hold for a negative x1 and a positive x2
	logic [2:0] brFunct [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
	rvPkg::regAddrT takenRs1 [6] = '{5'd1, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1};
	rvPkg::regAddrT takenRs2 [6] = '{5'd1, 5'd2, 5'd2, 5'd1, 5'd1, 5'd2};
	rvPkg::regAddrT notRs1 [6] = '{5'd1, 5'd1, 5'd2, 5'd1, 5'd1, 5'd2};
	rvPkg::regAddrT notRs2 [6] = '{5'd2, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1};
	int slotOff [3] = '{0, 8, 4};
	int jumpOff [3] = '{8, -4, 8};

	rvCore UUT (
		.rstn(rstn), .rstN(rstN), .run(run),
		.imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
		.halted(halted), .retireValid(retireValid), .retireRegWrite(retireRegWrite),
		.retirePc(retirePc), .retireRdData(retireRdData), .retireRd(retireRd)
	);

	always #2 rstn = ~rstn;

	function automatic rvPkg::wordT encR(input logic [6:0] f7, input rvPkg::regAddrT rs2,
		input rvPkg::regAddrT rs1, input logic [2:0] f3, input rvPkg::regAddrT rd);
		return {f7, rs2, rs1, f3, rd, rvPkg::opReg};
	endfunction

	function automatic rvPkg::wordT encI(input logic [11:0] imm, input rvPkg::regAddrT rs1,
		input logic [2:0] f3, input rvPkg::regAddrT rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic rvPkg::wordT encS(input logic [11:0] imm, input rvPkg::regAddrT rs2,
		input rvPkg::regAddrT rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rvPkg::opStore};
	endfunction

	function automatic rvPkg::wordT encB(input logic [12:0] imm, input rvPkg::regAddrT rs2,
		input rvPkg::regAddrT rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvPkg::opBranch};
	endfunction

	function automatic rvPkg::wordT encU(input logic [19:0] imm, input rvPkg::regAddrT rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic rvPkg::wordT encJ(input logic [20:0] imm, input rvPkg::regAddrT rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvPkg::opJal};
	endfunction

	task automatic storeBytes(input rvPkg::wordT addr, input rvPkg::wordT value, input int size);
		for (int i = 0; i < size; i++) begin
			dmemModel[addr + i] = value[8 * i +: 8];
		end
	endtask

	function automatic rvPkg::wordT loadValue(input rvPkg::wordT addr, input int size,
		input logic zeroExt);
		rvPkg::wordT v;
		int i;
		v = '0;
		for (i = size - 1; i >= 0; i--) begin
			v = (v << 8) | {24'b0, dmemModel[addr + i]};
		end
		if (!zeroExt && size < 4 && v[8 * size - 1]) begin
			v = v | (32'hffff_ffff << (8 * size));
		end
		return v;
	endfunction

	task automatic addExpect(input rvPkg::wordT pcV, input logic wr, input rvPkg::regAddrT rd,
		input rvPkg::wordT data);
		expPc[expCount] = pcV;
		expWr[expCount] = wr;
		expRd[expCount] = rd;
		expData[expCount] = data;
		expCount++;
	endtask

	task automatic step(input rvPkg::wordT word, input logic wr, input rvPkg::regAddrT rd,
		input rvPkg::wordT data);
		image[buildPc[7:2]] = word;
		addExpect(buildPc, wr, rd, data);
		buildPc = buildPc + 32'd4;
	endtask

	// LUI of the rounded upper part, then ADDI of the low twelve bits
	task automatic loadConst(input rvPkg::regAddrT rd, input rvPkg::wordT value);
		rvPkg::wordT upper;
		upper = (value + 32'h800) & 32'hffff_f000;
		step(encU(upper[31:12], rd, rvPkg::opLui), 1'b1, rd, upper);
		step(encI(value[11:0], rd, 3'd0, rd, rvPkg::opImm), 1'b1, rd, value);
	endtask

	task automatic buildProgram();
		rvPkg::wordT a, b, ie, sraV, sraiV, base, at;
		logic [4:0] sh;
		int g, k, i;
		// Unused words retire as addi x31 and so show up as a wrong pc
		for (i = 0; i < rvPkg::imemWords; i++) begin
			image[i] = encI(12'(4 * i), 5'd0, 3'd0, 5'd31, rvPkg::opImm);
		end
		expCount = 0;
		buildPc = '0;
		a = $urandom | 32'h8000_0080;
		b = ($urandom & 32'h7fff_ff7f) | 32'h0000_8000;
		sh = b[4:0];
		ie = {{20{immVal[11]}}, immVal};
		sraV = $signed(a) >>> sh;
		sraiV = $signed(a) >>> shiftI;
		loadConst(5'd1, a);
		loadConst(5'd2, b);

		step(encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 1'b1, 5'd3, a + b);
		step(encR(7'h20, 5'd2, 5'd1, 3'd0, 5'd4), 1'b1, 5'd4, a - b);
		step(encR(7'h00, 5'd2, 5'd1, 3'd1, 5'd5), 1'b1, 5'd5, a << sh);
		step(encR(7'h00, 5'd2, 5'd1, 3'd2, 5'd6), 1'b1, 5'd6, {31'b0, $signed(a) < $signed(b)});
		step(encR(7'h00, 5'd2, 5'd1, 3'd3, 5'd7), 1'b1, 5'd7, {31'b0, a < b});
		step(encR(7'h00, 5'd2, 5'd1, 3'd4, 5'd8), 1'b1, 5'd8, a ^ b);
		step(encR(7'h00, 5'd2, 5'd1, 3'd5, 5'd9), 1'b1, 5'd9, a >> sh);
		step(encR(7'h20, 5'd2, 5'd1, 3'd5, 5'd10), 1'b1, 5'd10, sraV);
		step(encR(7'h00, 5'd2, 5'd1, 3'd6, 5'd11), 1'b1, 5'd11, a | b);
		step(encR(7'h00, 5'd2, 5'd1, 3'd7, 5'd12), 1'b1, 5'd12, a & b);

		step(encI(immVal, 5'd1, 3'd0, 5'd13, rvPkg::opImm), 1'b1, 5'd13, a + ie);
		step(encI(immVal, 5'd1, 3'd2, 5'd14, rvPkg::opImm), 1'b1, 5'd14,
			{31'b0, $signed(a) < $signed(ie)});
		step(encI(immVal, 5'd1, 3'd3, 5'd15, rvPkg::opImm), 1'b1, 5'd15, {31'b0, a < ie});
		step(encI(immVal, 5'd1, 3'd4, 5'd16, rvPkg::opImm), 1'b1, 5'd16, a ^ ie);
		step(encI(immVal, 5'd1, 3'd6, 5'd17, rvPkg::opImm), 1'b1, 5'd17, a | ie);
		step(encI(immVal, 5'd1, 3'd7, 5'd18, rvPkg::opImm), 1'b1, 5'd18, a & ie);
		step(encI({7'h00, shiftI}, 5'd1, 3'd1, 5'd19, rvPkg::opImm), 1'b1, 5'd19, a << shiftI);
		step(encI({7'h00, shiftI}, 5'd1, 3'd5, 5'd20, rvPkg::opImm), 1'b1, 5'd20, a >> shiftI);
		step(encI({7'h20, shiftI}, 5'd1, 3'd5, 5'd21, rvPkg::opImm), 1'b1, 5'd21, sraiV);

		// x0 write retires but the next read still sees zero
		step(encI(12'd5, 5'd1, 3'd0, 5'd0, rvPkg::opImm), 1'b1, 5'd0, a + 32'd5);
		step(encR(7'h00, 5'd2, 5'd0, 3'd0, 5'd22), 1'b1, 5'd22, b);
		step(encU(20'h12345, 5'd23, rvPkg::opAuipc), 1'b1, 5'd23, buildPc + 32'h1234_5000);

		step(encS(12'h040, 5'd1, 5'd0, 3'd2), 1'b0, 5'd0, '0);
		storeBytes(32'h40, a, 4);
		step(encS(12'h041, 5'd2, 5'd0, 3'd0), 1'b0, 5'd0, '0);
		storeBytes(32'h41, b, 1);
		step(encS(12'h042, 5'd2, 5'd0, 3'd1), 1'b0, 5'd0, '0);
		storeBytes(32'h42, b, 2);
		step(encI(12'h040, 5'd0, 3'd2, 5'd24, rvPkg::opLoad), 1'b1, 5'd24,
			loadValue(32'h40, 4, 1'b0));
		for (i = 0; i < 4; i++) begin
			at = 32'h40 + i;
			step(encI(at[11:0], 5'd0, 3'd0, 5'd25, rvPkg::opLoad), 1'b1, 5'd25,
				loadValue(at, 1, 1'b0));
			step(encI(at[11:0], 5'd0, 3'd4, 5'd26, rvPkg::opLoad), 1'b1, 5'd26,
				loadValue(at, 1, 1'b1));
		end
		for (i = 0; i < 4; i += 2) begin
			at = 32'h40 + i;
			step(encI(at[11:0], 5'd0, 3'd1, 5'd27, rvPkg::opLoad), 1'b1, 5'd27,
				loadValue(at, 2, 1'b0));
			step(encI(at[11:0], 5'd0, 3'd5, 5'd28, rvPkg::opLoad), 1'b1, 5'd28,
				loadValue(at, 2, 1'b1));
		end

		// Taken branches chain forward 8 then back 4 then forward 8 so no word is skipped
		for (g = 0; g < 2; g++) begin
			base = buildPc;
			for (k = 0; k < 3; k++) begin
				i = 3 * g + k;
				at = base + slotOff[k];
				image[at[7:2]] = encB(13'(jumpOff[k]), takenRs2[i], takenRs1[i], brFunct[i]);
				addExpect(at, 1'b0, 5'd0, '0);
			end
			buildPc = base + 32'd12;
		end
		for (i = 0; i < 6; i++) begin
			step(encB(13'd8, notRs2[i], notRs1[i], brFunct[i]), 1'b0, 5'd0, '0);
		end

		// JALR lands on rs1 + 13 with bit 0 cleared
		base = buildPc;
		step(encJ(21'd8, 5'd21), 1'b1, 5'd21, base + 32'd4);
		buildPc = base + 32'd8;
		step(encI(12'd13, 5'd21, 3'd0, 5'd29, rvPkg::opJalr), 1'b1, 5'd29, base + 32'd12);
		buildPc = base + 32'd16;
		step(encI(12'd1, 5'd29, 3'd0, 5'd30, rvPkg::opImm), 1'b1, 5'd30, base + 32'd13);
		image[buildPc[7:2]] = '0;
	endtask

	task automatic stopOnFailure();
		$display("Simulation FAILED");
		$fatal(1, "stopping at the first failure");
	endtask

	task automatic checkValue(input string what, input rvPkg::wordT got, input rvPkg::wordT exp);
		if (got !== exp) begin
			$display("ERROR at time %0t: %s is %h, expected %h", $time, what, got, exp);
			stopOnFailure();
		end
	endtask

	task automatic loadProgram();
		for (int i = 0; i < rvPkg::imemWords; i++) begin
			@(posedge rstn);
			#1;
			imemWe = 1'b1;
			imemAddr = rvPkg::imemAddrT'(i);
			imemData = image[i];
		end
		@(posedge rstn);
		#1;
		imemWe = 1'b0;
	endtask

	task automatic waitRetire(input int entry);
		int cycles;
		cycles = 0;
		@(negedge rstn);
		while (!retireValid && cycles < retireTimeout) begin
			cycles++;
			@(negedge rstn);
		end
		if (!retireValid) begin
			$display("Timeout: entry %0d did not retire within %0d cycles",
				entry, retireTimeout);
			stopOnFailure();
		end
	endtask

	task automatic waitHalt();
		int cycles;
		cycles = 0;
		@(negedge rstn);
		while (!halted && cycles < haltTimeout) begin
			if (retireValid) begin
				$display("Unexpected retire at pc %h before the core halted", retirePc);
				stopOnFailure();
			end
			cycles++;
			@(negedge rstn);
		end
		if (!halted) begin
			$display("Timeout: halted did not rise within %0d cycles", haltTimeout);
			stopOnFailure();
		end
	endtask

	task automatic watchQuiet();
		for (int i = 0; i < quietCycles; i++) begin
			@(negedge rstn);
			if (retireValid) begin
				$display("Instruction at pc %h retired after the core halted", retirePc);
				stopOnFailure();
			end
		end
	endtask

	initial begin
		rstn = 1'b0;
		rstN = 1'b0;
		run = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		void'($urandom(4));
		buildProgram();
		repeat (3) @(posedge rstn);
		#1;
		rstN = 1'b1;
		loadProgram();
		@(posedge rstn);
		#1;
		run = 1'b1;
		for (int e = 0; e < expCount; e++) begin
			waitRetire(e);
			checkValue($sformatf("entry %0d retirePc", e), retirePc, expPc[e]);
			checkValue($sformatf("entry %0d retireRegWrite", e), {31'b0, retireRegWrite},
				{31'b0, expWr[e]});
			// Rd and data only mean something when a register is written
			if (expWr[e]) begin
				checkValue($sformatf("entry %0d retireRd", e), {27'b0, retireRd},
					{27'b0, expRd[e]});
				checkValue($sformatf("entry %0d retireRdData", e), retireRdData, expData[e]);
			end
		end
		waitHalt();
		watchQuiet();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: sources.f
rvPkg.sv
rvDecoder.sv
rvImmGen.sv
rvRegFile.sv
rvAlu.sv
rvFetch.sv
rvLoadStore.sv
rvCore.sv
rvCoreTb.sv
